/* source/mpram_pkg.sv */
package mpram_pkg;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // memory shape
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int WIDTH     = 32;   // data word.
  localparam int ADDR_BITS = 8;
  localparam int NUM_ADDR  = 256;  // also the init sweep length.

  localparam int NUM_WR = 4;       // write ports.
  localparam int NUM_RD = 2;       // read ports, one sram replica each.

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write queue
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  localparam int Q_DEPTH    = 8;
  localparam int Q_PTR_BITS = 3;   // circular pointer.
  localparam int Q_CNT_BITS = 4;   // holds 0..Q_DEPTH.
  localparam int PUSH_BITS  = 3;   // push count 0..NUM_WR.
  localparam int BP_BITS    = 4;   // host threshold.

endpackage

/* source/sdp_ram.sv */
`timescale 1ns/1ps

module sdp_ram (
  input  logic                            clk,
  input  logic                            we,
  input  logic [mpram_pkg::ADDR_BITS-1:0] wadr,
  input  logic [mpram_pkg::WIDTH-1:0]     wdin,
  input  logic                            re,
  input  logic [mpram_pkg::ADDR_BITS-1:0] radr,
  output logic [mpram_pkg::WIDTH-1:0]     rdout
);
  import mpram_pkg::*;

  logic [WIDTH-1:0] mem [NUM_ADDR];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[wadr] <= wdin;
    end
  end

  // same-address read sees the word before this write.
  always_ff @(posedge clk) begin
    if (re) begin
      rdout <= mem[radr];
    end
  end

endmodule

/* source/wr_packer.sv */
`timescale 1ns/1ps

module wr_packer (
  input  logic [mpram_pkg::NUM_WR-1:0]                      write,
  input  logic [mpram_pkg::NUM_WR*mpram_pkg::ADDR_BITS-1:0] wr_adr,
  input  logic [mpram_pkg::NUM_WR*mpram_pkg::WIDTH-1:0]     din,
  input  logic                                              wr_bp,
  output logic [mpram_pkg::PUSH_BITS-1:0]                   push_cnt,
  output logic [mpram_pkg::NUM_WR*mpram_pkg::ADDR_BITS-1:0] push_adr,
  output logic [mpram_pkg::NUM_WR*mpram_pkg::WIDTH-1:0]     push_din
);
  import mpram_pkg::*;

  logic [NUM_WR-1:0]    keep;
  logic [PUSH_BITS-1:0] slot;

  // highest port wins on an address collision.
  always_comb begin
    for (int i = 0; i < NUM_WR; i++) begin
      keep[i] = write[i] & ~wr_bp;
      for (int j = i + 1; j < NUM_WR; j++) begin
        if (write[j] &&
            wr_adr[j*ADDR_BITS +: ADDR_BITS] == wr_adr[i*ADDR_BITS +: ADDR_BITS]) begin
          keep[i] = 1'b0;
        end
      end
    end
  end

  // compact survivors, lowest port first.
  always_comb begin
    slot     = '0;
    push_adr = '0;
    push_din = '0;
    for (int i = 0; i < NUM_WR; i++) begin
      if (keep[i]) begin
        push_adr[slot*ADDR_BITS +: ADDR_BITS] = wr_adr[i*ADDR_BITS +: ADDR_BITS];
        push_din[slot*WIDTH +: WIDTH]         = din[i*WIDTH +: WIDTH];
        slot = slot + 1'b1;
      end
    end
    push_cnt = slot;
  end

endmodule

/* source/wr_queue.sv */
`timescale 1ns/1ps

module wr_queue (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic [mpram_pkg::PUSH_BITS-1:0]                   push_cnt,
  input  logic [mpram_pkg::NUM_WR*mpram_pkg::ADDR_BITS-1:0] push_adr,
  input  logic [mpram_pkg::NUM_WR*mpram_pkg::WIDTH-1:0]     push_din,
  input  logic [mpram_pkg::BP_BITS-1:0]                     bp_thr,
  input  logic                                              ready,
  output logic                                              wr_bp,
  output logic                                              head_valid,
  output logic [mpram_pkg::ADDR_BITS-1:0]                   head_adr,
  output logic [mpram_pkg::WIDTH-1:0]                       head_din,
  input  logic                                              head_ready,
  input  logic [mpram_pkg::ADDR_BITS-1:0]                   srch_adr_0,
  input  logic [mpram_pkg::ADDR_BITS-1:0]                   srch_adr_1,
  output logic                                              srch_hit_0,
  output logic [mpram_pkg::WIDTH-1:0]                       srch_din_0,
  output logic                                              srch_hit_1,
  output logic [mpram_pkg::WIDTH-1:0]                       srch_din_1
);
  import mpram_pkg::*;

  logic [ADDR_BITS-1:0]  q_adr [Q_DEPTH];
  logic [WIDTH-1:0]      q_din [Q_DEPTH];
  logic [Q_PTR_BITS-1:0] wptr;
  logic [Q_PTR_BITS-1:0] rptr;
  logic [Q_CNT_BITS-1:0] cnt;
  logic                  pop;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // storage and pointers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  assign head_valid = (cnt != '0);
  assign head_adr   = q_adr[rptr];
  assign head_din   = q_din[rptr];
  assign pop        = head_valid & head_ready;

  always_ff @(posedge clk) begin
    for (int k = 0; k < NUM_WR; k++) begin
      if (k < int'(push_cnt)) begin
        q_adr[wptr + Q_PTR_BITS'(k)] <= push_adr[k*ADDR_BITS +: ADDR_BITS];
        q_din[wptr + Q_PTR_BITS'(k)] <= push_din[k*WIDTH +: WIDTH];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wptr <= '0;
      rptr <= '0;
      cnt  <= '0;
    end else begin
      wptr <= wptr + Q_PTR_BITS'(push_cnt);
      rptr <= rptr + Q_PTR_BITS'(pop);
      cnt  <= cnt + Q_CNT_BITS'(push_cnt) - Q_CNT_BITS'(pop);
    end
  end

  // room for a full beat of four is kept free.
  assign wr_bp = ~ready
               | ((bp_thr != '0) && (cnt >= Q_CNT_BITS'(bp_thr)))
               | (cnt > Q_CNT_BITS'(Q_DEPTH - NUM_WR));

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // address search for read forwarding
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // oldest to newest, so the last match is the newest.
  function automatic logic [WIDTH:0] search(input logic [ADDR_BITS-1:0] adr);
    logic [WIDTH:0]        res;
    logic [Q_PTR_BITS-1:0] idx;
    res = '0;
    for (int k = 0; k < Q_DEPTH; k++) begin
      idx = rptr + Q_PTR_BITS'(k);
      if (k < int'(cnt) && q_adr[idx] == adr) begin
        res = {1'b1, q_din[idx]};
      end
    end
    return res;
  endfunction

  always_comb begin
    {srch_hit_0, srch_din_0} = search(srch_adr_0);
    {srch_hit_1, srch_din_1} = search(srch_adr_1);
  end

endmodule

/* source/wr_drain.sv */
`timescale 1ns/1ps

module wr_drain (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            head_valid,
  input  logic [mpram_pkg::ADDR_BITS-1:0] head_adr,
  input  logic [mpram_pkg::WIDTH-1:0]     head_din,
  output logic                            head_ready,
  output logic                            ready,
  output logic                            ram_we,
  output logic [mpram_pkg::ADDR_BITS-1:0] ram_wadr,
  output logic [mpram_pkg::WIDTH-1:0]     ram_wdin
);
  import mpram_pkg::*;

  typedef enum logic [1:0] {IDLE, INIT, RUN} state_t;

  state_t               state;
  logic [ADDR_BITS-1:0] init_adr;
  logic                 init_on;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      init_adr <= '0;
    end else begin
      case (state)
        IDLE: state <= INIT;
        INIT: begin
          init_adr <= init_adr + 1'b1;
          if (init_adr == ADDR_BITS'(NUM_ADDR - 1)) state <= RUN;
        end
        default: state <= RUN;
      endcase
    end
  end

  assign init_on    = (state == INIT);
  assign ready      = (state == RUN);
  assign head_ready = ready;

  // write lands in the same cycle as the pop.
  assign ram_we   = init_on | (head_valid & head_ready);
  assign ram_wadr = init_on ? init_adr : head_adr;
  assign ram_wdin = init_on ? '0 : head_din;

endmodule

/* source/rd_port.sv */
`timescale 1ns/1ps

module rd_port (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            ready,
  input  logic                            read,
  input  logic [mpram_pkg::ADDR_BITS-1:0] rd_adr,
  output logic [mpram_pkg::ADDR_BITS-1:0] srch_adr,
  output logic                            ram_re,
  output logic [mpram_pkg::ADDR_BITS-1:0] ram_radr,
  input  logic                            srch_hit,
  input  logic [mpram_pkg::WIDTH-1:0]     srch_din,
  input  logic [mpram_pkg::WIDTH-1:0]     ram_rdout,
  output logic                            rd_vld,
  output logic [mpram_pkg::WIDTH-1:0]     rd_dout
);
  import mpram_pkg::*;

  logic             req;
  logic             vld_q;
  logic             hit_q;
  logic [WIDTH-1:0] fwd_q;

  assign req      = read & ready;  // reads during init are dropped.
  assign ram_re   = req;
  assign ram_radr = rd_adr;
  assign srch_adr = rd_adr;

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= req;
    end
  end

  always_ff @(posedge clk) begin
    hit_q <= srch_hit;
    fwd_q <= srch_din;
  end

  assign rd_vld  = vld_q;
  assign rd_dout = hit_q ? fwd_q : ram_rdout;  // queued data is newer.

endmodule

/* source/mpram_top.sv */
`timescale 1ns/1ps

module mpram_top (
  input  logic                                              clk,
  input  logic                                              rst,
  output logic                                              ready,
  input  logic [mpram_pkg::NUM_WR-1:0]                      write,
  input  logic [mpram_pkg::NUM_WR*mpram_pkg::ADDR_BITS-1:0] wr_adr,
  input  logic [mpram_pkg::NUM_WR*mpram_pkg::WIDTH-1:0]     din,
  output logic                                              wr_bp,
  input  logic [mpram_pkg::NUM_RD-1:0]                      read,
  input  logic [mpram_pkg::NUM_RD*mpram_pkg::ADDR_BITS-1:0] rd_adr,
  output logic [mpram_pkg::NUM_RD-1:0]                      rd_vld,
  output logic [mpram_pkg::NUM_RD*mpram_pkg::WIDTH-1:0]     rd_dout,
  input  logic [mpram_pkg::BP_BITS-1:0]                     bp_thr
);
  import mpram_pkg::*;

  logic [PUSH_BITS-1:0]        push_cnt;
  logic [NUM_WR*ADDR_BITS-1:0] push_adr;
  logic [NUM_WR*WIDTH-1:0]     push_din;

  logic                 head_valid;
  logic                 head_ready;
  logic [ADDR_BITS-1:0] head_adr;
  logic [WIDTH-1:0]     head_din;

  logic                 ram_we;
  logic [ADDR_BITS-1:0] ram_wadr;
  logic [WIDTH-1:0]     ram_wdin;

  logic [ADDR_BITS-1:0] srch_adr_0, srch_adr_1;
  logic                 srch_hit_0, srch_hit_1;
  logic [WIDTH-1:0]     srch_din_0, srch_din_1;
  logic                 ram_re_0, ram_re_1;
  logic [ADDR_BITS-1:0] ram_radr_0, ram_radr_1;
  logic [WIDTH-1:0]     ram_rdout_0, ram_rdout_1;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write path
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  wr_packer u_wr_packer (
    .write(write), .wr_adr(wr_adr), .din(din), .wr_bp(wr_bp),
    .push_cnt(push_cnt), .push_adr(push_adr), .push_din(push_din)
  );

  wr_queue u_wr_queue (
    .clk(clk), .rst(rst),
    .push_cnt(push_cnt), .push_adr(push_adr), .push_din(push_din),
    .bp_thr(bp_thr), .ready(ready), .wr_bp(wr_bp),
    .head_valid(head_valid), .head_adr(head_adr), .head_din(head_din),
    .head_ready(head_ready),
    .srch_adr_0(srch_adr_0), .srch_adr_1(srch_adr_1),
    .srch_hit_0(srch_hit_0), .srch_din_0(srch_din_0),
    .srch_hit_1(srch_hit_1), .srch_din_1(srch_din_1)
  );

  wr_drain u_wr_drain (
    .clk(clk), .rst(rst),
    .head_valid(head_valid), .head_adr(head_adr), .head_din(head_din),
    .head_ready(head_ready), .ready(ready),
    .ram_we(ram_we), .ram_wadr(ram_wadr), .ram_wdin(ram_wdin)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one replica per read port
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  sdp_ram u_ram_0 (
    .clk(clk), .we(ram_we), .wadr(ram_wadr), .wdin(ram_wdin),
    .re(ram_re_0), .radr(ram_radr_0), .rdout(ram_rdout_0)
  );

  sdp_ram u_ram_1 (
    .clk(clk), .we(ram_we), .wadr(ram_wadr), .wdin(ram_wdin),
    .re(ram_re_1), .radr(ram_radr_1), .rdout(ram_rdout_1)
  );

  rd_port u_rd_0 (
    .clk(clk), .rst(rst), .ready(ready),
    .read(read[0]), .rd_adr(rd_adr[0 +: ADDR_BITS]),
    .srch_adr(srch_adr_0), .ram_re(ram_re_0), .ram_radr(ram_radr_0),
    .srch_hit(srch_hit_0), .srch_din(srch_din_0), .ram_rdout(ram_rdout_0),
    .rd_vld(rd_vld[0]), .rd_dout(rd_dout[0 +: WIDTH])
  );

  rd_port u_rd_1 (
    .clk(clk), .rst(rst), .ready(ready),
    .read(read[1]), .rd_adr(rd_adr[ADDR_BITS +: ADDR_BITS]),
    .srch_adr(srch_adr_1), .ram_re(ram_re_1), .ram_radr(ram_radr_1),
    .srch_hit(srch_hit_1), .srch_din(srch_din_1), .ram_rdout(ram_rdout_1),
    .rd_vld(rd_vld[1]), .rd_dout(rd_dout[WIDTH +: WIDTH])
  );

endmodule

/* dv/tb_clk.sv */
`timescale 1ns/1ps

module tb_clk (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period.
  end

endmodule

/* dv/mpram_checker.sv */
`timescale 1ns/1ps

module mpram_checker (
  input  logic                                              clk,
  input  logic                                              rst,
  input  logic                                              ready,
  input  logic [mpram_pkg::NUM_WR-1:0]                      write,
  input  logic [mpram_pkg::NUM_WR*mpram_pkg::ADDR_BITS-1:0] wr_adr,
  input  logic [mpram_pkg::NUM_WR*mpram_pkg::WIDTH-1:0]     din,
  input  logic                                              wr_bp,
  input  logic [mpram_pkg::NUM_RD-1:0]                      read,
  input  logic [mpram_pkg::NUM_RD*mpram_pkg::ADDR_BITS-1:0] rd_adr,
  input  logic [mpram_pkg::NUM_RD-1:0]                      rd_vld,
  input  logic [mpram_pkg::NUM_RD*mpram_pkg::WIDTH-1:0]     rd_dout,
  input  logic [mpram_pkg::BP_BITS-1:0]                     bp_thr,
  output int                                                errors,
  output int                                                reads_done
);
  import mpram_pkg::*;

  logic [WIDTH-1:0]  model [NUM_ADDR];
  logic [WIDTH-1:0]  expect_dout [NUM_RD];
  logic [NUM_RD-1:0] pending;
  int                occ;  // model queue occupancy.

  always @(posedge clk) begin : check
    logic             bp_exp;
    logic             dup;
    int               push;
    logic [WIDTH-1:0] got;
    if (rst) begin
      for (int a = 0; a < NUM_ADDR; a++) begin
        model[a] = '0;
      end
      pending    = '0;
      occ        = 0;
      errors     = 0;
      reads_done = 0;
    end else begin
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      // results of reads taken on the previous edge
      // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
      for (int p = 0; p < NUM_RD; p++) begin
        got = rd_dout[p*WIDTH +: WIDTH];
        if (pending[p] && !rd_vld[p]) begin
          $display("%0t: read port %0d gave no rd_vld after its request", $time, p);
          errors++;
        end else if (!pending[p] && rd_vld[p]) begin
          $display("FAILED %0t rd_vld[%0d] expected 0 got 1", $time, p);
          errors++;
        end else if (pending[p]) begin
          reads_done++;
          if (got !== expect_dout[p]) begin
            $display("FAILED %0t rd_dout[%0d] expected %h got %h",
                     $time, p, expect_dout[p], got);
            errors++;
          end
        end
      end
      bp_exp = !ready || (bp_thr != '0 && occ >= int'(bp_thr)) || occ > Q_DEPTH - NUM_WR;
      if (wr_bp !== bp_exp) begin
        $display("FAILED %0t wr_bp expected %b got %b", $time, bp_exp, wr_bp);
        errors++;
      end
      // reads see the memory before this edge's writes.
      for (int p = 0; p < NUM_RD; p++) begin
        pending[p]     = read[p] & ready;
        expect_dout[p] = model[rd_adr[p*ADDR_BITS +: ADDR_BITS]];
      end
      push = 0;
      for (int i = 0; i < NUM_WR; i++) begin
        dup = 1'b0;
        for (int j = i + 1; j < NUM_WR; j++) begin
          dup |= write[j] &&
                 wr_adr[j*ADDR_BITS +: ADDR_BITS] == wr_adr[i*ADDR_BITS +: ADDR_BITS];
        end
        if (write[i] && !wr_bp) begin
          model[wr_adr[i*ADDR_BITS +: ADDR_BITS]] = din[i*WIDTH +: WIDTH];
          push += dup ? 0 : 1;  // later port overwrites.
        end
      end
      occ = occ + push - ((ready && occ > 0) ? 1 : 0);
    end
  end

endmodule

/* dv/mpram_tb.sv */
`timescale 1ns/1ps

module mpram_tb;
  import mpram_pkg::*;

  logic                        clk;
  logic                        rst;
  logic                        ready;
  logic [NUM_WR-1:0]           write;
  logic [NUM_WR*ADDR_BITS-1:0] wr_adr;
  logic [NUM_WR*WIDTH-1:0]     din;
  logic                        wr_bp;
  logic [NUM_RD-1:0]           read;
  logic [NUM_RD*ADDR_BITS-1:0] rd_adr;
  logic [NUM_RD-1:0]           rd_vld;
  logic [NUM_RD*WIDTH-1:0]     rd_dout;
  logic [BP_BITS-1:0]          bp_thr;
  int                          errors;
  int                          reads_done;
  int                          tb_errors;
  int                          err_mark;
  logic [31:0]                 lfsr;
  logic [ADDR_BITS-1:0]        recent [NUM_WR];  // last address per write port.

  tb_clk u_tb_clk (.clk(clk));

  mpram_top u_mpram_top (.*);

  mpram_checker u_checker (.*);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // stimulus helpers
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);  // galois step.
    end
    return val;
  endfunction

  task automatic abort_run(input string why);
    $display("%0t: %s", $time, why);
    $display("Regression failed");
    $finish;
  endtask

  task automatic drive_cycle(input logic [NUM_WR-1:0] wmask, input int abits, input bit near);
    int n;
    for (int i = 0; i < NUM_WR; i++) begin
      wr_adr[i*ADDR_BITS +: ADDR_BITS] = ADDR_BITS'(rand_bits(abits));
      din[i*WIDTH +: WIDTH]            = rand_bits(WIDTH);
    end
    for (int p = 0; p < NUM_RD; p++) begin
      rd_adr[p*ADDR_BITS +: ADDR_BITS] = near ? recent[2'(rand_bits(2))]
                                              : ADDR_BITS'(rand_bits(abits));
    end
    write = wmask;
    read  = NUM_RD'(rand_bits(NUM_RD));
    n = 0;
    while (write != '0 && wr_bp && n < 100) begin
      @(negedge clk);
      n++;
    end
    if (write != '0 && wr_bp) begin
      abort_run("writes were held off by wr_bp for 100 cycles");
    end else begin
      for (int i = 0; i < NUM_WR; i++) begin
        if (wmask[i]) recent[i] = wr_adr[i*ADDR_BITS +: ADDR_BITS];
      end
      @(negedge clk);
      write = '0;
      read  = '0;
    end
  endtask

  task automatic end_test(input int num, input string name);
    write = '0;
    read  = '0;
    repeat (2) @(negedge clk);  // let the last read come back.
    $display("test %0d %s: %0d errors", num, name, errors + tb_errors - err_mark);
    err_mark = errors + tb_errors;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // test sequence
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial begin
    int n;
    lfsr      = 32'h69e4b5a6;
    rst       = 1'b1;
    write     = '0;
    wr_adr    = '0;
    din       = '0;
    read      = '0;
    rd_adr    = '0;
    bp_thr    = '0;
    tb_errors = 0;
    err_mark  = 0;
    for (int i = 0; i < NUM_WR; i++) begin
      recent[i] = '0;
    end
    repeat (3) @(negedge clk);
    rst = 1'b0;

    n = 0;
    while (!ready && n < 2 * NUM_ADDR) begin
      read = NUM_RD'(rand_bits(NUM_RD));  // must be ignored during init.
      @(negedge clk);
      n++;
    end
    if (!ready) begin
      abort_run("ready did not rise after the init sweep");
    end else if (wr_bp) begin
      $display("FAILED %0t wr_bp expected 0 got %b", $time, wr_bp);
      tb_errors++;
    end
    repeat (20) drive_cycle('0, ADDR_BITS, 1'b0);
    end_test(1, "init");

    repeat (200) drive_cycle(NUM_WR'(1) << rand_bits(2), 4, 1'b0);
    end_test(2, "single-port writes");

    repeat (200) drive_cycle('1, 2, 1'b0);  // four addresses keep ports colliding.
    end_test(3, "collisions");

    repeat (200) drive_cycle('1, 5, 1'b1);
    end_test(4, "forwarding");

    for (int c = 0; c < 300; c++) begin
      if (c % 25 == 0) begin
        bp_thr = BP_BITS'(rand_bits(BP_BITS));
        @(negedge clk);  // wr_bp follows the new threshold.
      end
      drive_cycle(NUM_WR'(rand_bits(NUM_WR)), 4, 1'b1);
    end
    bp_thr = '0;
    end_test(5, "back-pressure");

    $display("5 tests, %0d reads checked, %0d errors", reads_done, errors + tb_errors);
    if (errors + tb_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* all.f */
source/mpram_pkg.sv
source/sdp_ram.sv
source/wr_packer.sv
source/wr_queue.sv
source/wr_drain.sv
source/rd_port.sv
source/mpram_top.sv
dv/tb_clk.sv
dv/mpram_checker.sv
dv/mpram_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module mpram_tb -f all.f -o mpram_sim \
  && ./obj_dir/mpram_sim | tee /dev/stderr | grep -q "Regression passed" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
